//--- hdl/mxu_types_pkg.sv
`default_nettype none

package mxu_types_pkg;

    // ==========================================================
    // operand and accumulator widths
    // ==========================================================

    localparam int DATA_W = 8;                  // signed operand bits
    localparam int PROD_W = 2 * DATA_W;         // full 8x8 product
    localparam int ACC_W  = 20;                 // headroom over four 16-bit terms

    // four lanes per row, one per array row or column
    localparam int ROW_W  = 4 * DATA_W;         // packed input / weight row
    localparam int OUT_W  = 4 * ACC_W;          // packed result row

    // ==========================================================
    // datapath types
    // ==========================================================

    typedef logic signed [DATA_W-1:0] elem_t;   // one operand
    typedef logic signed [ACC_W-1:0]  acc_t;    // one column sum

    // lane k sits at bits [k*DATA_W +: DATA_W]
    typedef logic [ROW_W-1:0] row_t;            // x vector or weight row

    // lane k sits at bits [k*ACC_W +: ACC_W]
    typedef logic [OUT_W-1:0] out_vec_t;        // result row

endpackage

`default_nettype wire

//--- hdl/mxu_ctrl_pkg.sv
`default_nettype none

package mxu_ctrl_pkg;

    // ==========================================================
    // array geometry and memory sizes
    // ==========================================================

    localparam int ARR_DIM   = 4;               // 4x4 systolic array
    localparam int VEC_DEPTH = 16;              // input / output memory rows

    typedef logic [$clog2(VEC_DEPTH)-1:0] vec_addr_t;  // input/output row address
    typedef logic [$clog2(ARR_DIM)-1:0]   w_addr_t;    // weight row address
    typedef logic [$clog2(VEC_DEPTH):0]   cnt_t;       // 1..16 vectors, also step count

    // ==========================================================
    // command sequencer
    // ==========================================================

    typedef enum logic [1:0] {
        S_IDLE,                                 // waiting for a command
        S_WLOAD,                                // shifting weight rows into the array
        S_STREAM,                               // one input vector per cycle
        S_FLUSH                                 // pipeline draining, wait for done
    } seq_state_t;

endpackage

`default_nettype wire

//--- hdl/operand_feed.sv
`timescale 1ns/1ps
`default_nettype none

module operand_feed
    import mxu_types_pkg::*;
    import mxu_ctrl_pkg::*;
(
    input  logic             clk,
    input  logic             rst,
    input  logic             in_wr_en,      // host write, input memory
    input  vec_addr_t        in_wr_addr,
    input  row_t             in_wr_data,
    input  logic             w_wr_en,       // host write, weight memory
    input  w_addr_t          w_wr_addr,
    input  row_t             w_wr_data,
    input  logic             load_weights,  // command pulses
    input  logic             start,
    input  cnt_t             vec_count,
    input  logic             relu_en,
    input  logic             done,          // last row written by out_stage
    output logic             busy,
    output logic             weights_done,
    output logic             w_shift,
    output row_t             w_row,
    output row_t             x_skew,
    output logic [ARR_DIM-1:0] x_valid_skew,
    output logic             relu_mode,
    output logic             stream_last
);

    row_t       in_mem [VEC_DEPTH];         // host-written input vectors
    row_t       w_mem  [ARR_DIM];           // host-written weight rows
    seq_state_t state;
    cnt_t       step;                       // row counter for load and stream
    cnt_t       vec_total;                  // vec_count latched at start
    w_addr_t    w_rd_addr;
    row_t       x_rd;                       // unskewed vector from memory
    logic       x_rd_valid;

    // done ends the run this cycle, so a new command can already be taken
    assign busy      = (state != S_IDLE) && !done;
    assign w_rd_addr = w_addr_t'(ARR_DIM - 1) - w_addr_t'(step);  // row 3 goes in first

    always_ff @(posedge clk) begin
        if (in_wr_en) in_mem[in_wr_addr] <= in_wr_data;
        if (w_wr_en) w_mem[w_wr_addr] <= w_wr_data;
        w_row <= w_mem[w_rd_addr];                  // registered read, lines up with w_shift
        x_rd  <= in_mem[vec_addr_t'(step)];         // lines up with x_rd_valid
    end

    // ==========================================================
    // command decode and sequencing
    // ==========================================================

    always_ff @(posedge clk) begin
        if (rst) begin
            state        <= S_IDLE;
            step         <= '0;
            vec_total    <= '0;
            relu_mode    <= 1'b0;
            w_shift      <= 1'b0;
            weights_done <= 1'b0;
            x_rd_valid   <= 1'b0;
            stream_last  <= 1'b0;
        end else begin
            w_shift      <= 1'b0;                   // pulses by default
            weights_done <= 1'b0;
            x_rd_valid   <= 1'b0;
            stream_last  <= 1'b0;
            if (!busy && load_weights) begin
                state <= S_WLOAD;
                step  <= '0;
            end else if (!busy && start && vec_count != '0) begin
                state     <= S_STREAM;
                step      <= '0;
                vec_total <= vec_count;
                relu_mode <= relu_en;               // held for the whole run
            end else begin
                case (state)
                    S_WLOAD: begin
                        step <= step + cnt_t'(1);
                        if (step == cnt_t'(ARR_DIM)) begin  // last row already shifted
                            state        <= S_IDLE;
                            weights_done <= 1'b1;
                        end else begin
                            w_shift <= 1'b1;
                        end
                    end
                    S_STREAM: begin
                        step       <= step + cnt_t'(1);
                        x_rd_valid <= 1'b1;
                        if (step == vec_total - cnt_t'(1)) begin
                            stream_last <= 1'b1;    // tags the final vector
                            state       <= S_FLUSH;
                        end
                    end
                    S_FLUSH: if (done) state <= S_IDLE;
                    default: state <= S_IDLE;
                endcase
            end
        end
    end

    // ==========================================================
    // input skew, lane i delayed i cycles
    // ==========================================================

    for (genvar i = 0; i < ARR_DIM; i++) begin : g_skew
        if (i == 0) begin : g_direct
            assign x_skew[0 +: DATA_W] = x_rd[0 +: DATA_W];
            assign x_valid_skew[0]     = x_rd_valid;
        end else begin : g_delay
            elem_t        dly_q [i];                // payload, no reset
            logic [i-1:0] vld_q;
            always_ff @(posedge clk) begin
                dly_q[0] <= x_rd[i*DATA_W +: DATA_W];
                for (int k = 1; k < i; k++) begin
                    dly_q[k] <= dly_q[k-1];
                end
            end
            always_ff @(posedge clk) begin
                if (rst) begin
                    vld_q <= '0;
                end else begin
                    vld_q[0] <= x_rd_valid;
                    for (int k = 1; k < i; k++) begin
                        vld_q[k] <= vld_q[k-1];
                    end
                end
            end
            assign x_skew[i*DATA_W +: DATA_W] = dly_q[i-1];
            assign x_valid_skew[i]            = vld_q[i-1];
        end
    end

endmodule

`default_nettype wire

//--- hdl/pe_array.sv
`timescale 1ns/1ps
`default_nettype none

module pe_array
    import mxu_types_pkg::*;
    import mxu_ctrl_pkg::*;
(
    input  logic               clk,
    input  logic               rst,
    input  logic               w_shift,       // weights move down one row
    input  row_t               w_row,         // enters PE row 0
    input  row_t               x_skew,        // lane i enters row i from the left
    input  logic [ARR_DIM-1:0] x_valid_skew,
    output out_vec_t           col_sum,       // lane j skewed j cycles
    output logic [ARR_DIM-1:0] col_valid
);

    // PE(i,j) state, i = row, j = column
    elem_t x_q   [ARR_DIM][ARR_DIM];        // x passed to the right
    elem_t w_q   [ARR_DIM][ARR_DIM];        // stationary weight W[i][j]
    acc_t  sum_q [ARR_DIM][ARR_DIM];        // partial sum passed down
    logic  v_q   [ARR_DIM][ARR_DIM];        // valid rides with x

    // ==========================================================
    // PE grid
    // ==========================================================

    for (genvar i = 0; i < ARR_DIM; i++) begin : g_row
        for (genvar j = 0; j < ARR_DIM; j++) begin : g_col
            elem_t                    x_in;
            elem_t                    w_in;
            acc_t                     sum_in;
            logic                     v_in;
            logic signed [PROD_W-1:0] prod;

            if (j == 0) begin : g_left
                assign x_in = x_skew[i*DATA_W +: DATA_W];
                assign v_in = x_valid_skew[i];
            end else begin : g_inner
                assign x_in = x_q[i][j-1];
                assign v_in = v_q[i][j-1];
            end

            if (i == 0) begin : g_top
                assign sum_in = '0;                     // no bias input
                assign w_in   = w_row[j*DATA_W +: DATA_W];
            end else begin : g_below
                assign sum_in = sum_q[i-1][j];
                assign w_in   = w_q[i-1][j];
            end

            assign prod = x_in * w_q[i][j];             // signed 8x8

            always_ff @(posedge clk) begin
                if (w_shift) begin
                    w_q[i][j] <= w_in;                  // weight load, feed is idle
                end else begin
                    x_q[i][j]   <= x_in;
                    sum_q[i][j] <= v_in ? sum_in + acc_t'(prod) : sum_in;  // idle slots add 0
                end
            end

            always_ff @(posedge clk) begin
                if (rst) begin
                    v_q[i][j] <= 1'b0;
                end else if (!w_shift) begin
                    v_q[i][j] <= v_in;
                end
            end
        end
    end

    // ==========================================================
    // bottom row drives the column outputs
    // ==========================================================

    for (genvar j = 0; j < ARR_DIM; j++) begin : g_out
        assign col_sum[j*ACC_W +: ACC_W] = sum_q[ARR_DIM-1][j];
        assign col_valid[j]              = v_q[ARR_DIM-1][j];
    end

endmodule

`default_nettype wire

//--- hdl/out_stage.sv
`timescale 1ns/1ps
`default_nettype none

module out_stage
    import mxu_types_pkg::*;
    import mxu_ctrl_pkg::*;
(
    input  logic               clk,
    input  logic               rst,
    input  out_vec_t           col_sum,       // lane j skewed j cycles
    input  logic [ARR_DIM-1:0] col_valid,
    input  logic               relu_mode,
    input  logic               stream_last,   // pulse with the last issued vector
    input  vec_addr_t          rd_addr,       // host read
    output out_vec_t           rd_data,
    output logic               done
);

    acc_t                   lane_al [ARR_DIM];  // deskewed lanes
    logic [ARR_DIM-1:0]     vld_al;
    logic                   row_ok;             // whole row aligned
    out_vec_t               wr_row;
    vec_addr_t              wr_addr;
    logic [2*ARR_DIM-2:0]   last_q;             // stream_last through array latency
    logic                   last_row;
    out_vec_t               out_mem [VEC_DEPTH];

    // ==========================================================
    // deskew, lane j delayed ARR_DIM-1-j cycles
    // ==========================================================

    for (genvar j = 0; j < ARR_DIM; j++) begin : g_deskew
        if (j == ARR_DIM - 1) begin : g_direct
            assign lane_al[j] = col_sum[j*ACC_W +: ACC_W];
            assign vld_al[j]  = col_valid[j];
        end else begin : g_delay
            acc_t                  dly_q [ARR_DIM-1-j];
            logic [ARR_DIM-2-j:0]  vld_q;
            always_ff @(posedge clk) begin
                dly_q[0] <= col_sum[j*ACC_W +: ACC_W];
                for (int k = 1; k < ARR_DIM - 1 - j; k++) begin
                    dly_q[k] <= dly_q[k-1];
                end
                if (rst) begin
                    vld_q <= '0;
                end else begin
                    vld_q[0] <= col_valid[j];
                    for (int k = 1; k < ARR_DIM - 1 - j; k++) begin
                        vld_q[k] <= vld_q[k-1];
                    end
                end
            end
            assign lane_al[j] = dly_q[ARR_DIM-2-j];
            assign vld_al[j]  = vld_q[ARR_DIM-2-j];
        end
    end

    assign row_ok   = &vld_al;
    assign last_row = last_q[2*ARR_DIM-2];      // 7 cycles: 4 rows down + 3 columns across

    always_comb begin
        for (int j = 0; j < ARR_DIM; j++) begin
            if (relu_mode && lane_al[j][ACC_W-1]) begin
                wr_row[j*ACC_W +: ACC_W] = '0;  // negative lane clamped
            end else begin
                wr_row[j*ACC_W +: ACC_W] = lane_al[j];
            end
        end
    end

    // ==========================================================
    // write control and output memory
    // ==========================================================

    always_ff @(posedge clk) begin
        if (rst) begin
            last_q  <= '0;
            wr_addr <= '0;
            done    <= 1'b0;
        end else begin
            last_q <= {last_q[2*ARR_DIM-3:0], stream_last};
            done   <= row_ok && last_row;       // high once the last row is stored
            if (row_ok) wr_addr <= last_row ? '0 : wr_addr + vec_addr_t'(1);
        end
    end

    always_ff @(posedge clk) begin
        if (row_ok) out_mem[wr_addr] <= wr_row;
        rd_data <= out_mem[rd_addr];            // one-cycle read latency
    end

endmodule

`default_nettype wire

//--- hdl/mxu_top.sv
`timescale 1ns/1ps
`default_nettype none

module mxu_top
    import mxu_types_pkg::*;
    import mxu_ctrl_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      in_wr_en,
    input  vec_addr_t in_wr_addr,
    input  row_t      in_wr_data,
    input  logic      w_wr_en,
    input  w_addr_t   w_wr_addr,
    input  row_t      w_wr_data,
    input  logic      load_weights,
    input  logic      start,
    input  cnt_t      vec_count,
    input  logic      relu_en,
    input  vec_addr_t rd_addr,
    output out_vec_t  rd_data,
    output logic      busy,
    output logic      weights_done,
    output logic      done
);

    logic               w_shift;            // feed -> array
    row_t               w_row;
    row_t               x_skew;
    logic [ARR_DIM-1:0] x_valid_skew;
    out_vec_t           col_sum;            // array -> output stage
    logic [ARR_DIM-1:0] col_valid;
    logic               relu_mode;          // feed -> output stage
    logic               stream_last;

    // decode
    operand_feed u_feed (
        .clk         (clk),
        .rst         (rst),
        .in_wr_en    (in_wr_en),
        .in_wr_addr  (in_wr_addr),
        .in_wr_data  (in_wr_data),
        .w_wr_en     (w_wr_en),
        .w_wr_addr   (w_wr_addr),
        .w_wr_data   (w_wr_data),
        .load_weights(load_weights),
        .start       (start),
        .vec_count   (vec_count),
        .relu_en     (relu_en),
        .done        (done),                // closes the flush wait
        .busy        (busy),
        .weights_done(weights_done),
        .w_shift     (w_shift),
        .w_row       (w_row),
        .x_skew      (x_skew),
        .x_valid_skew(x_valid_skew),
        .relu_mode   (relu_mode),
        .stream_last (stream_last)
    );

    // execute
    pe_array u_pe (
        .clk         (clk),
        .rst         (rst),
        .w_shift     (w_shift),
        .w_row       (w_row),
        .x_skew      (x_skew),
        .x_valid_skew(x_valid_skew),
        .col_sum     (col_sum),
        .col_valid   (col_valid)
    );

    // result
    out_stage u_out (
        .clk        (clk),
        .rst        (rst),
        .col_sum    (col_sum),
        .col_valid  (col_valid),
        .relu_mode  (relu_mode),
        .stream_last(stream_last),
        .rd_addr    (rd_addr),
        .rd_data    (rd_data),
        .done       (done)
    );

endmodule

`default_nettype wire

//--- bench/mxu_chk.sv
`timescale 1ns/1ps
`default_nettype none

module mxu_chk (
    input logic clk,
    input logic rst,
    input logic busy,
    input logic done,
    input logic weights_done
);

    int unsigned fail_cnt = 0;              // failed assertions so far

    // ==========================================================
    // control output protocol
    // ==========================================================

    a_done_pulse: assert property (@(posedge clk) disable iff (rst) done |=> !done)
        else begin
            fail_cnt++;
            $error("done stayed high for more than one cycle");
        end

    a_wdone_pulse: assert property (@(posedge clk) disable iff (rst)
        weights_done |=> !weights_done)
        else begin
            fail_cnt++;
            $error("weights_done stayed high for more than one cycle");
        end

    // busy high through the run, low in the done cycle
    a_busy_falls: assert property (@(posedge clk) disable iff (rst) done |-> $fell(busy))
        else begin
            fail_cnt++;
            $error("busy did not fall in the done cycle");
        end

    // all status low right after reset
    a_reset_idle: assert property (@(posedge clk) $past(rst) |-> !busy && !done && !weights_done)
        else begin
            fail_cnt++;
            $error("status outputs not low after reset");
        end

endmodule

bind mxu_top mxu_chk u_chk (
    .clk         (clk),
    .rst         (rst),
    .busy        (busy),
    .done        (done),
    .weights_done(weights_done)
);

`default_nettype wire

//--- bench/tb_mxu.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mxu
    import mxu_types_pkg::*;
    import mxu_ctrl_pkg::*;
();

    // ==========================================================
    // run length and timeout budget
    // ==========================================================

    localparam int NUM_TESTS   = 5;
    localparam int VEC_SUM     = 4 + 16 + 16 + 1 + 8;          // vec_count of each test
    localparam int CYCLE_LIMIT = (VEC_SUM + 40) * NUM_TESTS;

    logic      clk = 1'b0;
    logic      rst;
    logic      in_wr_en;
    vec_addr_t in_wr_addr;
    row_t      in_wr_data;
    logic      w_wr_en;
    w_addr_t   w_wr_addr;
    row_t      w_wr_data;
    logic      load_weights;
    logic      start;
    cnt_t      vec_count;
    logic      relu_en;
    vec_addr_t rd_addr;
    out_vec_t  rd_data;
    logic      busy;
    logic      weights_done;
    logic      done;

    elem_t  w_ref [ARR_DIM][ARR_DIM];       // bench copy of W[i][j]
    elem_t  x_ref [VEC_DEPTH][ARR_DIM];     // bench copy of x vectors
    integer seed      = 55205;
    int     errors    = 0;
    int     checks    = 0;
    int     done_cnt  = 0;                  // done pulses seen
    int     wdone_cnt = 0;                  // weights_done pulses seen
    int     cycles    = 0;

    mxu_top u_dut (.*);

    always #4 clk = ~clk;                   // 8 ns period

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("ERROR: timeout, the DUT did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Done: errors found");
            $finish;
        end
    end

    // ==========================================================
    // reference model and compare tasks
    // ==========================================================

    function automatic out_vec_t ref_row(input int v, input logic relu);
        out_vec_t r;
        int       sum;
        for (int j = 0; j < ARR_DIM; j++) begin
            sum = 0;
            for (int i = 0; i < ARR_DIM; i++) begin
                sum += int'(x_ref[v][i]) * int'(w_ref[i][j]);   // column j dot product
            end
            if (relu && sum < 0) sum = 0;
            r[j*ACC_W +: ACC_W] = acc_t'(sum);
        end
        return r;
    endfunction

    task automatic check_vec(input string name, input out_vec_t exp, input out_vec_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Fail %0t %s: expected %h, got %h", $time, name, exp, act);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Fail %0t %s: expected %b, got %b", $time, name, exp, act);
        end
    endtask

    // one cycle, inputs and samples 1 ns after the edge
    task automatic tick();
        @(posedge clk);
        #1;
        if (done) done_cnt++;
        if (weights_done) wdone_cnt++;
    endtask

    // ==========================================================
    // host side tasks
    // ==========================================================

    task automatic write_weights();
        row_t r;
        for (int i = 0; i < ARR_DIM; i++) begin
            for (int j = 0; j < ARR_DIM; j++) r[j*DATA_W +: DATA_W] = w_ref[i][j];
            w_wr_en   = 1'b1;
            w_wr_addr = w_addr_t'(i);
            w_wr_data = r;
            tick();
        end
        w_wr_en = 1'b0;
    endtask

    task automatic write_vectors(input int n);
        row_t r;
        for (int v = 0; v < n; v++) begin
            for (int i = 0; i < ARR_DIM; i++) begin
                x_ref[v][i] = elem_t'($random(seed));
                r[i*DATA_W +: DATA_W] = x_ref[v][i];
            end
            in_wr_en   = 1'b1;
            in_wr_addr = vec_addr_t'(v);
            in_wr_data = r;
            tick();
        end
        in_wr_en = 1'b0;
    endtask

    task automatic rand_weights();
        for (int i = 0; i < ARR_DIM; i++) begin
            for (int j = 0; j < ARR_DIM; j++) w_ref[i][j] = elem_t'($random(seed));
        end
    endtask

    // returns cycles from the load_weights cycle to weights_done
    task automatic load_weights_timed(output int lat);
        load_weights = 1'b1;
        tick();
        load_weights = 1'b0;
        lat = 1;
        while (!weights_done) begin
            tick();
            lat++;
        end
    endtask

    task automatic run_vectors(input int n, input logic relu);
        vec_count = cnt_t'(n);
        relu_en   = relu;
        start     = 1'b1;
        tick();
        start = 1'b0;
        while (!done) tick();               // timeout block guards this
    endtask

    task automatic check_results(input int n, input logic relu);
        for (int a = 0; a < n; a++) begin
            rd_addr = vec_addr_t'(a);
            tick();                         // one-cycle read latency
            check_vec($sformatf("rd_data[%0d]", a), ref_row(a, relu), rd_data);
        end
    endtask

    task automatic report_test(input string name, input int mark);
        if (errors == mark) $display("test %s: passed", name);
        else $display("test %s: %0d errors", name, errors - mark);
    endtask

    // ==========================================================
    // test sequence
    // ==========================================================

    initial begin
        int lat;
        int mark;
        rst          = 1'b1;
        in_wr_en     = 1'b0;
        in_wr_addr   = '0;
        in_wr_data   = '0;
        w_wr_en      = 1'b0;
        w_wr_addr    = '0;
        w_wr_data    = '0;
        load_weights = 1'b0;
        start        = 1'b0;
        vec_count    = '0;
        relu_en      = 1'b0;
        rd_addr      = '0;
        repeat (8) tick();
        rst = 1'b0;
        tick();

        mark = errors;                      // identity weights pass x through
        for (int i = 0; i < ARR_DIM; i++) begin
            for (int j = 0; j < ARR_DIM; j++) w_ref[i][j] = (i == j) ? 8'sd1 : 8'sd0;
        end
        write_weights();
        write_vectors(4);
        load_weights_timed(lat);
        check_flag("weights_done_after_6", 1'b1, lat == 6);
        run_vectors(4, 1'b0);
        check_results(4, 1'b0);
        report_test("1 identity", mark);

        mark = errors;
        rand_weights();
        write_weights();
        write_vectors(16);
        load_weights_timed(lat);
        run_vectors(16, 1'b0);
        check_results(16, 1'b0);
        report_test("2 random", mark);

        mark = errors;                      // same operands, negatives clamped
        run_vectors(16, 1'b1);
        check_results(16, 1'b1);
        report_test("3 relu", mark);

        mark = errors;
        rand_weights();
        write_weights();
        load_weights_timed(lat);
        run_vectors(1, 1'b0);               // start right on weights_done
        check_results(1, 1'b0);
        report_test("4 reload", mark);

        mark = errors;
        done_cnt  = 0;
        wdone_cnt = 0;
        vec_count = cnt_t'(8);
        relu_en   = 1'b0;
        start     = 1'b1;
        tick();
        start = 1'b0;
        tick();
        check_flag("busy", 1'b1, busy);
        load_weights = 1'b1;                // must be dropped
        tick();
        load_weights = 1'b0;
        vec_count    = cnt_t'(3);           // stray start with another count
        start        = 1'b1;
        tick();
        start = 1'b0;
        while (!done) tick();
        repeat (20) tick();                 // room for a wrongly started second run
        check_flag("done_once", 1'b1, done_cnt == 1);
        check_flag("no_weights_done", 1'b1, wdone_cnt == 0);
        check_flag("busy", 1'b0, busy);
        check_results(8, 1'b0);
        report_test("5 busy commands", mark);

        errors = errors + int'(u_dut.u_chk.fail_cnt);
        $display("tests: %0d, checks: %0d, assertion failures: %0d, errors: %0d",
                 NUM_TESTS, checks, u_dut.u_chk.fail_cnt, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- flist.f
hdl/mxu_types_pkg.sv
hdl/mxu_ctrl_pkg.sv
hdl/operand_feed.sv
hdl/pe_array.sv
hdl/out_stage.sv
hdl/mxu_top.sv
bench/mxu_chk.sv
bench/tb_mxu.sv

//--- Makefile
TOOL       := verilator
TOP        := tb_mxu
FLIST      := flist.f
FLAGS      := --binary --timing --assert -Wno-fatal
LINT_FLAGS := --lint-only --timing --assert
BUILD      := obj_dir
LOG        := sim.log
SIM_ARGS   := +verilator+error+limit+100
PASS_MSG   := Done: no errors
FAIL_MSG   := Done: errors found

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FLIST)
	./$(BUILD)/V$(TOP) $(SIM_ARGS) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation ended early"; exit 1; fi
	@echo "simulation passed"

clean:
	rm -rf $(BUILD) $(LOG)
